//--- hw/alu_execute.sv
`timescale 1ns/100ps
`default_nettype none

`include "int_pipe_defs.svh"

module alu_execute (
    input  wire      aclk,
    input  wire      rst,
    issue_if.sink    iss,
    result_if.source res
);
    import int_pipe_pkg::*;

    opcode_t  op_q;
    reg_idx_t rd_q;
    data_t    opa_q;
    data_t    opb_q;
    data_t    res_q;
    data_t    alu_out;
    logic     opnd_vld_q;
    logic     res_vld_q;
    logic     iss_fire;

    // stage holds one item, operands for a cycle and then the result
    assign iss.ready = !opnd_vld_q && (!res_vld_q || res.ready);
    assign iss_fire  = iss.valid && iss.ready;

    always_ff @(posedge aclk) begin
        if (rst) begin
            opnd_vld_q <= 1'b0;
            res_vld_q  <= 1'b0;
        end else begin
            opnd_vld_q <= iss_fire;
            if (opnd_vld_q) begin
                res_vld_q <= 1'b1;
            end else if (res.ready) begin
                res_vld_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (iss_fire) begin
            op_q  <= iss.op;
            rd_q  <= iss.rd;
            opa_q <= iss.opa;
            opb_q <= iss.opb;
        end
        if (opnd_vld_q) begin
            res_q <= alu_out;
        end
    end

    always_comb begin
        case (op_q)
            `INT_PIPE_OP_ADD,
            `INT_PIPE_OP_ADDI: alu_out = opa_q + opb_q;
            `INT_PIPE_OP_SUB:  alu_out = opa_q - opb_q;
            `INT_PIPE_OP_AND:  alu_out = opa_q & opb_q;
            `INT_PIPE_OP_OR:   alu_out = opa_q | opb_q;
            `INT_PIPE_OP_XOR:  alu_out = opa_q ^ opb_q;
            `INT_PIPE_OP_SLT:  alu_out = {{(`INT_PIPE_XLEN-1){1'b0}},
                                         ($signed(opa_q) < $signed(opb_q))};
            `INT_PIPE_OP_SLL:  alu_out = opa_q << opb_q[4:0];
            // immediate already shifted up in decode
            `INT_PIPE_OP_LUI:  alu_out = opb_q;
            default:           alu_out = '0;
        endcase
    end

    assign res.valid = res_vld_q;
    assign res.rd    = rd_q;
    assign res.data  = res_q;

endmodule

`default_nettype wire

//--- hw/inst_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "int_pipe_defs.svh"

module inst_decode (
    input  wire                         aclk,
    input  wire                         rst,
    input  wire                         inst_valid_i,
    output logic                        inst_ready_o,
    input  wire int_pipe_pkg::inst_t    inst_i,
    output int_pipe_pkg::reg_idx_t      rs_a_o,
    output int_pipe_pkg::reg_idx_t      rs_b_o,
    output int_pipe_pkg::reg_idx_t      chk_rd_o,
    input  wire int_pipe_pkg::data_t    rdata_a_i,
    input  wire int_pipe_pkg::data_t    rdata_b_i,
    input  wire                         busy_a_i,
    input  wire                         busy_b_i,
    input  wire                         busy_rd_i,
    output logic                        set_busy_o,
    output int_pipe_pkg::reg_idx_t      set_rd_o,
    issue_if.source                     iss
);
    import int_pipe_pkg::*;

    inst_t       inst_q;
    logic        full_q;
    opcode_t     op;
    reg_idx_t    rd;
    reg_idx_t    rs;
    reg_idx_t    rt;
    logic [15:0] imm;
    logic        uses_rs;
    logic        uses_rt;
    logic        hazard;
    logic        issue_fire;
    data_t       opb;

    assign op  = inst_q[31:28];
    assign rd  = inst_q[27:24];
    assign rs  = inst_q[23:20];
    assign rt  = inst_q[19:16];
    assign imm = inst_q[15:0];

    // LUI reads no register, ADDI reads only rs
    assign uses_rs = (op != `INT_PIPE_OP_LUI);
    assign uses_rt = (op != `INT_PIPE_OP_LUI) && (op != `INT_PIPE_OP_ADDI);

    // the destination is checked too so results leave in order per register
    assign hazard = (uses_rs && busy_a_i) || (uses_rt && busy_b_i) || busy_rd_i;

    assign issue_fire   = iss.valid && iss.ready;
    assign inst_ready_o = !full_q || issue_fire;

    always_ff @(posedge aclk) begin
        if (rst) begin
            full_q <= 1'b0;
        end else if (inst_valid_i && inst_ready_o) begin
            full_q <= 1'b1;
        end else if (issue_fire) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (inst_valid_i && inst_ready_o) begin
            inst_q <= inst_i;
        end
    end

    always_comb begin
        case (op)
            `INT_PIPE_OP_ADDI: opb = {{(`INT_PIPE_XLEN-16){imm[15]}}, imm};
            `INT_PIPE_OP_LUI:  opb = {imm, {(`INT_PIPE_XLEN-16){1'b0}}};
            default:           opb = rdata_b_i;
        endcase
    end

    assign rs_a_o   = rs;
    assign rs_b_o   = rt;
    assign chk_rd_o = rd;

    assign iss.valid = full_q && !hazard;
    assign iss.op    = op;
    assign iss.rd    = rd;
    assign iss.opa   = rdata_a_i;
    assign iss.opb   = opb;

    assign set_busy_o = issue_fire;
    assign set_rd_o   = rd;

endmodule

`default_nettype wire

//--- hw/int_pipe_pkg.sv
`default_nettype none

`include "int_pipe_defs.svh"

package int_pipe_pkg;

    // register or result value
    typedef logic [`INT_PIPE_XLEN-1:0] data_t;

    // architectural register number
    typedef logic [$clog2(`INT_PIPE_NREGS)-1:0] reg_idx_t;

    // operation code
    typedef logic [3:0] opcode_t;

    // instruction word
    //   31..28 opcode
    //   27..24 rd
    //   23..20 rs
    //   19..16 rt
    //   15..0  imm
    typedef logic [31:0] inst_t;

endpackage

`default_nettype wire

//--- hw/int_pipe_top.sv
`timescale 1ns/100ps
`default_nettype none

module int_pipe_top (
    input  wire                         aclk,
    input  wire                         rst,
    input  wire                         inst_valid_i,
    output wire                         inst_ready_o,
    input  wire int_pipe_pkg::inst_t    inst_i,
    output wire                         res_valid_o,
    input  wire                         res_ready_i,
    output wire int_pipe_pkg::reg_idx_t res_rd_o,
    output wire int_pipe_pkg::data_t    res_data_o
);
    import int_pipe_pkg::*;

    reg_idx_t rs_a;
    reg_idx_t rs_b;
    reg_idx_t chk_rd;
    data_t    rdata_a;
    data_t    rdata_b;
    logic     busy_a;
    logic     busy_b;
    logic     busy_rd;
    logic     set_busy;
    reg_idx_t set_rd;
    logic     wr_en;
    reg_idx_t wr_rd;
    data_t    wr_data;

    issue_if  iss_bus ();
    result_if res_bus ();

    reg_scoreboard reg_scoreboard_i (
        .aclk       (aclk),
        .rst        (rst),
        .rs_a_i     (rs_a),
        .rs_b_i     (rs_b),
        .chk_rd_i   (chk_rd),
        .rdata_a_o  (rdata_a),
        .rdata_b_o  (rdata_b),
        .busy_a_o   (busy_a),
        .busy_b_o   (busy_b),
        .busy_rd_o  (busy_rd),
        .set_busy_i (set_busy),
        .set_rd_i   (set_rd),
        .wr_en_i    (wr_en),
        .wr_rd_i    (wr_rd),
        .wr_data_i  (wr_data)
    );

    inst_decode inst_decode_i (
        .aclk         (aclk),
        .rst          (rst),
        .inst_valid_i (inst_valid_i),
        .inst_ready_o (inst_ready_o),
        .inst_i       (inst_i),
        .rs_a_o       (rs_a),
        .rs_b_o       (rs_b),
        .chk_rd_o     (chk_rd),
        .rdata_a_i    (rdata_a),
        .rdata_b_i    (rdata_b),
        .busy_a_i     (busy_a),
        .busy_b_i     (busy_b),
        .busy_rd_i    (busy_rd),
        .set_busy_o   (set_busy),
        .set_rd_o     (set_rd),
        .iss          (iss_bus.source)
    );

    alu_execute alu_execute_i (
        .aclk (aclk),
        .rst  (rst),
        .iss  (iss_bus.sink),
        .res  (res_bus.source)
    );

    result_commit result_commit_i (
        .aclk        (aclk),
        .rst         (rst),
        .res         (res_bus.sink),
        .res_ready_i (res_ready_i),
        .res_valid_o (res_valid_o),
        .res_rd_o    (res_rd_o),
        .res_data_o  (res_data_o),
        .wr_en_o     (wr_en),
        .wr_rd_o     (wr_rd),
        .wr_data_o   (wr_data)
    );

endmodule

`default_nettype wire

//--- hw/pipe_if.sv
`timescale 1ns/100ps
`default_nettype none

// decode to execute, one decoded instruction with its operands
interface issue_if;
    import int_pipe_pkg::*;

    logic     valid;
    logic     ready;
    opcode_t  op;
    reg_idx_t rd;
    data_t    opa;
    data_t    opb;

    modport source (output valid, output op, output rd, output opa, output opb, input ready);
    modport sink   (input valid, input op, input rd, input opa, input opb, output ready);
endinterface

// execute to result stage
interface result_if;
    import int_pipe_pkg::*;

    logic     valid;
    logic     ready;
    reg_idx_t rd;
    data_t    data;

    modport source (output valid, output rd, output data, input ready);
    modport sink   (input valid, input rd, input data, output ready);
endinterface

`default_nettype wire

//--- hw/reg_scoreboard.sv
`timescale 1ns/100ps
`default_nettype none

`include "int_pipe_defs.svh"

module reg_scoreboard (
    input  wire                         aclk,
    input  wire                         rst,
    input  wire int_pipe_pkg::reg_idx_t rs_a_i,
    input  wire int_pipe_pkg::reg_idx_t rs_b_i,
    input  wire int_pipe_pkg::reg_idx_t chk_rd_i,
    output int_pipe_pkg::data_t         rdata_a_o,
    output int_pipe_pkg::data_t         rdata_b_o,
    output logic                        busy_a_o,
    output logic                        busy_b_o,
    output logic                        busy_rd_o,
    input  wire                         set_busy_i,
    input  wire int_pipe_pkg::reg_idx_t set_rd_i,
    input  wire                         wr_en_i,
    input  wire int_pipe_pkg::reg_idx_t wr_rd_i,
    input  wire int_pipe_pkg::data_t    wr_data_i
);
    import int_pipe_pkg::*;

    data_t                     regs_q [`INT_PIPE_NREGS];
    logic [`INT_PIPE_NREGS-1:0] busy_q;

    // r0 is cleared by reset and never written, so it always reads zero
    always_ff @(posedge aclk) begin
        if (rst) begin
            regs_q <= '{default: '0};
        end else if (wr_en_i && (wr_rd_i != '0)) begin
            regs_q[wr_rd_i] <= wr_data_i;
        end
    end

    // set and clear never name the same register in one cycle,
    // decode only issues once the destination is no longer busy
    always_ff @(posedge aclk) begin
        if (rst) begin
            busy_q <= '0;
        end else begin
            if (wr_en_i && (wr_rd_i != '0)) begin
                busy_q[wr_rd_i] <= 1'b0;
            end
            if (set_busy_i && (set_rd_i != '0)) begin
                busy_q[set_rd_i] <= 1'b1;
            end
        end
    end

    assign rdata_a_o = regs_q[rs_a_i];
    assign rdata_b_o = regs_q[rs_b_i];

    assign busy_a_o  = busy_q[rs_a_i];
    assign busy_b_o  = busy_q[rs_b_i];
    assign busy_rd_o = busy_q[chk_rd_i];

endmodule

`default_nettype wire

//--- hw/result_commit.sv
`timescale 1ns/100ps
`default_nettype none

module result_commit (
    input  wire                     aclk,
    input  wire                     rst,
    result_if.sink                  res,
    input  wire                     res_ready_i,
    output logic                    res_valid_o,
    output int_pipe_pkg::reg_idx_t  res_rd_o,
    output int_pipe_pkg::data_t     res_data_o,
    output logic                    wr_en_o,
    output int_pipe_pkg::reg_idx_t  wr_rd_o,
    output int_pipe_pkg::data_t     wr_data_o
);
    import int_pipe_pkg::*;

    logic     valid_q;
    reg_idx_t rd_q;
    data_t    data_q;
    logic     in_fire;
    logic     out_fire;

    assign out_fire  = valid_q && res_ready_i;
    assign res.ready = !valid_q || res_ready_i;
    assign in_fire   = res.valid && res.ready;

    always_ff @(posedge aclk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_fire) begin
            valid_q <= 1'b1;
        end else if (out_fire) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (in_fire) begin
            rd_q   <= res.rd;
            data_q <= res.data;
        end
    end

    assign res_valid_o = valid_q;
    assign res_rd_o    = rd_q;
    assign res_data_o  = data_q;

    // writeback and busy clear happen on the output handshake
    assign wr_en_o   = out_fire;
    assign wr_rd_o   = rd_q;
    assign wr_data_o = data_q;

endmodule

`default_nettype wire

//--- include/int_pipe_defs.svh
`ifndef INT_PIPE_DEFS_SVH
`define INT_PIPE_DEFS_SVH

// datapath and register file size
`define INT_PIPE_XLEN   32
`define INT_PIPE_NREGS  16

// opcode values, instruction bits 31..28
`define INT_PIPE_OP_ADD   4'd0
`define INT_PIPE_OP_SUB   4'd1
`define INT_PIPE_OP_AND   4'd2
`define INT_PIPE_OP_OR    4'd3
`define INT_PIPE_OP_XOR   4'd4
`define INT_PIPE_OP_SLT   4'd5
`define INT_PIPE_OP_SLL   4'd6
`define INT_PIPE_OP_ADDI  4'd7
`define INT_PIPE_OP_LUI   4'd8

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the int_pipe testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        -f sources.f --top-module int_pipe_tb --Mdir obj_dir -o int_pipe_sim; then
    echo "build failed"
    exit 1
fi

./obj_dir/int_pipe_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
echo "simulation finished without failure"
exit 0

//--- sim/int_pipe_checker.sv
`timescale 1ns/100ps
`default_nettype none

module int_pipe_checker (
    input wire                         aclk,
    input wire                         rst,
    input wire                         inst_ready_i,
    input wire                         res_valid_i,
    input wire                         res_ready_i,
    input wire int_pipe_pkg::reg_idx_t res_rd_i,
    input wire int_pipe_pkg::data_t    res_data_i
);
    import int_pipe_pkg::*;

    // a stalled result keeps its valid and its payload
    property hold_while_stalled;
        @(posedge aclk) disable iff (rst)
        (res_valid_i && !res_ready_i) |=>
            (res_valid_i && $stable(res_rd_i) && $stable(res_data_i));
    endproperty

    // first cycle out of reset
    property idle_after_reset;
        @(posedge aclk) $fell(rst) |-> (inst_ready_i && !res_valid_i);
    endproperty

    property valid_known;
        @(posedge aclk) disable iff (rst) !$isunknown(res_valid_i);
    endproperty

    hold_chk: assert property (hold_while_stalled)
        else $error("result output changed while res_ready_i was low");
    reset_chk: assert property (idle_after_reset)
        else $error("pipeline not idle in the first cycle after reset");
    known_chk: assert property (valid_known)
        else $error("res_valid_o is unknown");

endmodule

bind int_pipe_top int_pipe_checker int_pipe_checker_i (
    .aclk         (aclk),
    .rst          (rst),
    .inst_ready_i (inst_ready_o),
    .res_valid_i  (res_valid_o),
    .res_ready_i  (res_ready_i),
    .res_rd_i     (res_rd_o),
    .res_data_i   (res_data_o)
);

`default_nettype wire

//--- sim/int_pipe_stim.txt
# columns: test name, instruction word (hex), expected rd (hex), expected value (hex)
# instruction fields: opcode 31..28, rd 27..24, rs 23..20, rt 19..16, imm 15..0
lui_r1          81001234  1  12340000
addi_r2_neg     7200fffb  2  fffffffb
addi_r3         73000100  3  00000100
addi_r4_from_r1 74105678  4  12345678
addi_r5_min     75008000  5  ffff8000
add_r6          06430000  6  12345778
sub_r7          17340000  7  edcbaa88
and_r8          28450000  8  12340000
or_r9           39130000  9  12340100
xor_r10         4a450000  a  edcbd678
slt_neg_pos     5b230000  b  00000001
slt_pos_neg     5c350000  c  00000000
slt_neg_neg     5d520000  d  00000001
addi_r15_shamt  7f000004  f  00000004
sll_r14         6e4f0000  e  23456780
chain_0         71000001  1  00000001
chain_1         01110000  1  00000002
chain_2         72100003  2  00000005
chain_3         13210000  3  00000003
chain_4         64230000  4  00000028
chain_5         45420000  5  0000002d
write_r0        7000007f  0  0000007f
read_r0_add     06050000  6  0000002d
read_r0_or      37000000  7  00000000
undef_op        c8450000  8  00000000
read_undef_dst  09830000  9  00000003

//--- sim/int_pipe_tb.sv
`timescale 1ns/100ps
`default_nettype none

module int_pipe_tb;
    import int_pipe_pkg::*;

    localparam int HALF_PERIOD     = 10;
    localparam int RESET_CYCLES    = 10;
    localparam int CYCLES_PER_TEST = 40;
    localparam int FIRST_LATENCY   = 3;

    logic     aclk;
    logic     rst;
    logic     inst_valid_i;
    logic     inst_ready_o;
    inst_t    inst_i;
    logic     res_valid_o;
    logic     res_ready_i;
    reg_idx_t res_rd_o;
    data_t    res_data_o;

    // stimulus and expected results, one entry per file line
    inst_t    inst_arr[$];
    string    name_q[$];
    reg_idx_t rd_q[$];
    data_t    data_q[$];

    int       num_tests  = 0;
    int       edge_cnt   = 0;
    int       acc_edge   = 0;
    logic     first_done = 1'b0;
    integer   seed       = 32'hafdd7b32;

    int_pipe_top int_pipe_top_i (
        .aclk         (aclk),
        .rst          (rst),
        .inst_valid_i (inst_valid_i),
        .inst_ready_o (inst_ready_o),
        .inst_i       (inst_i),
        .res_valid_o  (res_valid_o),
        .res_ready_i  (res_ready_i),
        .res_rd_o     (res_rd_o),
        .res_data_o   (res_data_o)
    );

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped after the first error");
    endtask

    task automatic check_rd(input string test, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            stop_with_error($sformatf("mismatch %s: expected rd %0d, actual rd %0d",
                                      test, exp, act));
        end
    endtask

    task automatic check_data(input string test, input data_t exp, input data_t act);
        if (act !== exp) begin
            stop_with_error($sformatf("mismatch %s: expected data 0x%08h, actual 0x%08h",
                                      test, exp, act));
        end
    endtask

    task automatic check_flag(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_error($sformatf("mismatch %s: expected %b, actual %b", test, exp, act));
        end
    endtask

    task automatic check_count(input string test, input int exp, input int act);
        if (act != exp) begin
            stop_with_error($sformatf("mismatch %s: expected %0d, actual %0d", test, exp, act));
        end
    endtask

    task automatic load_stimulus;
        int             fd;
        int             cnt;
        string          line;
        reg [8*32-1:0]  name_r;
        inst_t          inst_w;
        reg_idx_t       rd_w;
        data_t          data_w;
        fd = $fopen("sim/int_pipe_stim.txt", "r");
        if (fd == 0) begin
            stop_with_error("cannot open the stimulus file sim/int_pipe_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cnt  = $fgets(line, fd);
                // lines starting with # describe the columns
                if ((cnt > 0) && (line.getc(0) != "#")) begin
                    cnt = $sscanf(line, "%s %h %h %h", name_r, inst_w, rd_w, data_w);
                    if (cnt == 4) begin
                        name_q.push_back(string'(name_r));
                        inst_arr.push_back(inst_w);
                        rd_q.push_back(rd_w);
                        data_q.push_back(data_w);
                    end
                end
            end
            $fclose(fd);
            num_tests = inst_arr.size();
            if (num_tests == 0) begin
                stop_with_error("the stimulus file holds no tests");
            end
        end
    endtask

    initial begin
        aclk = 1'b0;
        forever begin
            #HALF_PERIOD aclk = ~aclk;
        end
    end

    always @(posedge aclk) begin
        edge_cnt <= edge_cnt + 1;
    end

    initial begin : drive_inputs
        int         idx;
        logic [1:0] gap;
        logic       fire;
        integer     rnd;
        rst          = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        res_ready_i  = 1'b1;
        idx          = 0;
        gap          = 2'd0;
        load_stimulus();
        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        rst = 1'b0;
        check_flag("reset inst_ready_o", 1'b1, inst_ready_o);
        check_flag("reset res_valid_o", 1'b0, res_valid_o);
        // first instruction goes in right away, output held ready
        inst_valid_i = 1'b1;
        inst_i       = inst_arr[0];
        forever begin
            @(posedge aclk);
            fire = inst_valid_i && inst_ready_o;
            if (fire && (idx == 0)) begin
                acc_edge = edge_cnt;
            end
            @(negedge aclk);
            rnd = $random(seed);
            if (first_done) begin
                res_ready_i = rnd[0];
            end
            if (fire) begin
                idx++;
                inst_valid_i = 1'b0;
                gap = rnd[5:4];
            end
            if (!inst_valid_i && (idx < num_tests)) begin
                if (gap == 2'd0) begin
                    inst_valid_i = 1'b1;
                    inst_i       = inst_arr[idx];
                end else begin
                    gap = gap - 2'd1;
                end
            end
        end
    end

    // results must leave in the order the instructions went in
    initial begin : check_results
        string    name;
        reg_idx_t exp_rd;
        data_t    exp_data;
        int       got;
        got = 0;
        wait (num_tests > 0);
        while (got < num_tests) begin
            @(posedge aclk);
            if (!rst && res_valid_o && res_ready_i) begin
                name     = name_q.pop_front();
                exp_rd   = rd_q.pop_front();
                exp_data = data_q.pop_front();
                if (got == 0) begin
                    check_count({name, " latency"}, FIRST_LATENCY, edge_cnt - acc_edge - 1);
                end
                check_rd(name, exp_rd, res_rd_o);
                check_data(name, exp_data, res_data_o);
                got++;
                first_done = 1'b1;
            end
        end
        $display("=== PASS ===");
        $finish;
    end

    initial begin : watchdog
        wait (num_tests > 0);
        repeat (num_tests * CYCLES_PER_TEST + RESET_CYCLES) @(posedge aclk);
        stop_with_error("timeout: results stopped arriving before all tests were checked");
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
hw/int_pipe_pkg.sv
hw/pipe_if.sv
hw/reg_scoreboard.sv
hw/inst_decode.sv
hw/alu_execute.sv
hw/result_commit.sv
hw/int_pipe_top.sv
sim/int_pipe_checker.sv
sim/int_pipe_tb.sv
